//--- Makefile
TOP = du_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f verilog.f --top-module $(TOP)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir

//--- src/du_bp_match.sv
`timescale 1ns/1ns
`default_nettype none

`include "du_defines.svh"

module du_bp_match (
  input  wire du_pkg::bp_reg_t [`DU_BREAKPOINTS-1:0] bp_i,
  input  wire                                        step_ena_i,
  input  wire                                        branch_ena_i,
  input  wire                                        if_nxt_bubble_i,
  input  wire [31:0]                                 if_insn_i,
  input  wire                                        if_bubble_i,
  input  wire [`DU_XLEN-1:0]                         pd_pc_i,
  input  wire                                        bu_flush_i,
  input  wire                                        st_flush_i,
  input  wire [31:0]                                 mem_insn_i,
  input  wire                                        mem_bubble_i,
  input  wire                                        mem_exc_i,
  input  wire [`DU_XLEN-1:0]                         mem_memadr_i,
  input  wire                                        dmem_ack_i,
  output logic [`DU_BREAKPOINTS-1:0]                 bp_hit_o,
  output logic                                       step_hit_o,
  output logic                                       branch_hit_o
);

  import du_pkg::*;

  logic mem_valid;
  logic mem_read;
  logic mem_write;

  assign step_hit_o   = step_ena_i & ~if_nxt_bubble_i;
  assign branch_hit_o = branch_ena_i & ~if_bubble_i &
                        (if_insn_i[2 +: `DU_OPC_W] == OPC_BRANCH);

  // Only completed, non-excepting memory accesses count
  assign mem_valid = ~mem_exc_i & ~mem_bubble_i & dmem_ack_i;
  assign mem_read  = mem_valid & (mem_insn_i[2 +: `DU_OPC_W] == OPC_LOAD);
  assign mem_write = mem_valid & (mem_insn_i[2 +: `DU_OPC_W] == OPC_STORE);

  always_comb
  begin
    for (int n = 0; n < `DU_BREAKPOINTS; n++)
    begin
      bp_hit_o[n] = 1'b0;
      if (bp_i[n].ena)
      begin
        case (bp_i[n].cc)
          CC_FETCH:    bp_hit_o[n] = (pd_pc_i == bp_i[n].data) & ~bu_flush_i & ~st_flush_i;
          CC_LD_ADR:   bp_hit_o[n] = (mem_memadr_i == bp_i[n].data) & mem_read;
          CC_ST_ADR:   bp_hit_o[n] = (mem_memadr_i == bp_i[n].data) & mem_write;
          CC_LDST_ADR: bp_hit_o[n] = (mem_memadr_i == bp_i[n].data) & (mem_read | mem_write);
          default:     bp_hit_o[n] = 1'b0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- src/du_defines.svh
`ifndef DU_DEFINES_SVH
`define DU_DEFINES_SVH

// Data path width
`define DU_XLEN 32

// Number of hardware breakpoints
`define DU_BREAKPOINTS 4

// Debug port address, bank select in the top four bits
`define DU_DBG_ADDR_W 16

// Address inside one bank
`define DU_DU_ADDR_W 12

// Exception vector from the core
// Low half holds traps, high half holds interrupts
`define DU_EXC_W 32

// Major opcode field, instruction bits 6:2
`define DU_OPC_W 5

`endif

//--- src/du_host_port.sv
`timescale 1ns/1ns
`default_nettype none

`include "du_defines.svh"

module du_host_port (
  input  wire                       clk_i,
  input  wire                       rst_ni,
  input  wire                       dbg_stall_i,
  input  wire                       dbg_strb_i,
  input  wire                       dbg_we_i,
  input  wire [`DU_DBG_ADDR_W-1:0]  dbg_addr_i,
  input  wire [`DU_XLEN-1:0]        dbg_d_i,
  input  wire                       ex_stall_i,
  input  wire                       hit_any_i,
  input  wire [`DU_XLEN-1:0]        du_rf_q_i,
  input  wire [`DU_XLEN-1:0]        if_nxt_pc_i,
  du_reg_if.host                    bus,
  output logic [`DU_XLEN-1:0]       dbg_q_o,
  output logic                      dbg_ack_o,
  output logic                      du_stall_o,
  output logic                      du_stall_if_o,
  output logic                      du_latch_nxt_pc_o,
  output logic                      du_flush_o,
  output logic                      du_we_rf_o,
  output logic                      du_we_pc_o,
  output logic [`DU_DU_ADDR_W-1:0]  du_addr_o,
  output logic [`DU_XLEN-1:0]       du_d_o
);

  import du_pkg::*;

  localparam int AW = `DU_DU_ADDR_W;

  du_bank_e   bank;
  logic       sel_internal;
  logic       sel_gprs;
  logic       gpr_is_rf;
  logic       gpr_is_npc;
  logic       du_access;
  logic       du_we;
  logic       strb_dly;
  logic       stall_dly;
  logic       ack_done;
  logic [2:0] du_ack;

  ////////////////////////////////////////////////////////////
  // Debug port decode and acknowledge
  ////////////////////////////////////////////////////////////

  assign bank         = du_bank_e'(dbg_addr_i[`DU_DBG_ADDR_W-1:AW]);
  assign sel_internal = (bank == BANK_INTERNAL);
  assign sel_gprs     = (bank == BANK_GPRS);
  assign gpr_is_rf    = (dbg_addr_i[AW-1:5] == '0);
  assign gpr_is_npc   = (dbg_addr_i[AW-1:0] == DU_GPR_NPC);

  // Core registers only reachable while the core is stalled
  assign du_access = dbg_strb_i & (sel_internal | dbg_stall_i);
  assign du_we     = du_access & ~strb_dly & dbg_we_i;

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      strb_dly  <= 1'b0;
      stall_dly <= 1'b0;
      ack_done  <= 1'b0;
    end
    else
    begin
      strb_dly  <= dbg_strb_i;
      stall_dly <= dbg_stall_i;
      ack_done  <= dbg_strb_i & (ack_done | dbg_ack_o);
    end
  end

  // Three stage shift, frozen while the pipeline stalls
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      du_ack <= '0;
    else if (!ex_stall_i)
      du_ack <= {3{du_access & ~dbg_ack_o & ~ack_done}} & {1'b1, du_ack[2:1]};
  end

  assign dbg_ack_o = du_ack[0];

  ////////////////////////////////////////////////////////////
  // Core side
  ////////////////////////////////////////////////////////////

  assign du_stall_o        = dbg_stall_i;
  assign du_stall_if_o     = dbg_stall_i | hit_any_i;
  assign du_latch_nxt_pc_o = dbg_stall_i & ~stall_dly;
  // Leaving debug may have changed program memory
  assign du_flush_o        = ~dbg_stall_i & stall_dly;

  always_ff @(posedge clk_i)
  begin
    du_addr_o <= dbg_addr_i[AW-1:0];
    du_d_o    <= dbg_d_i;
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      du_we_rf_o <= 1'b0;
      du_we_pc_o <= 1'b0;
      bus.we     <= 1'b0;
    end
    else
    begin
      du_we_rf_o <= du_we & sel_gprs & gpr_is_rf;
      du_we_pc_o <= du_we & sel_gprs & gpr_is_npc;
      bus.we     <= du_we & sel_internal;
    end
  end

  assign bus.addr  = du_addr_o;
  assign bus.wdata = du_d_o;

  // Read data, valid by the time ack rises
  always_ff @(posedge clk_i)
  begin
    if (sel_internal)
      dbg_q_o <= bus.rdata;
    else if (sel_gprs && gpr_is_npc)
      dbg_q_o <= if_nxt_pc_i;
    else if (sel_gprs && gpr_is_rf)
      dbg_q_o <= du_rf_q_i;
    else
      dbg_q_o <= '0;
  end

  a_ack_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dbg_ack_o && !ex_stall_i |=> !dbg_ack_o);

  // Core writes and bank writes never overlap
  a_we_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({du_we_rf_o, du_we_pc_o, bus.we}));

endmodule

`default_nettype wire

//--- src/du_pkg.sv
`default_nettype none

`include "du_defines.svh"

package du_pkg;

  // Bank select, top four bits of the debug address
  typedef enum logic [3:0] {
    BANK_INTERNAL = 4'h0,
    BANK_GPRS     = 4'h1
  } du_bank_e;

  // Internal register map, breakpoint n sits at BPCTRL0/BPDATA0 plus 2n
  typedef enum logic [`DU_DU_ADDR_W-1:0] {
    REG_CTRL    = 12'h000,
    REG_HIT     = 12'h001,
    REG_CAUSE   = 12'h002,
    REG_BPCTRL0 = 12'h010,
    REG_BPDATA0 = 12'h011
  } du_int_addr_e;

  // Next PC in the GPR bank, integer registers at 0x000..0x01F
  localparam logic [`DU_DU_ADDR_W-1:0] DU_GPR_NPC = 12'h200;

  // Breakpoint condition, unlisted codes never hit
  typedef enum logic [2:0] {
    CC_FETCH    = 3'd0,
    CC_LD_ADR   = 3'd1,
    CC_ST_ADR   = 3'd2,
    CC_LDST_ADR = 3'd3
  } bp_cc_e;

  typedef enum logic [`DU_OPC_W-1:0] {
    OPC_LOAD   = 5'h00,
    OPC_STORE  = 5'h08,
    OPC_BRANCH = 5'h18
  } opcode_e;

  typedef struct packed {
    logic                ena;
    bp_cc_e              cc;
    logic [`DU_XLEN-1:0] data;
  } bp_reg_t;

endpackage

`default_nettype wire

//--- src/du_reg_if.sv
`timescale 1ns/1ns
`default_nettype none

`include "du_defines.svh"

// Internal register bus between the debug port and the register bank
interface du_reg_if;

  logic                     we;
  logic [`DU_DU_ADDR_W-1:0] addr;
  logic [`DU_XLEN-1:0]      wdata;
  logic [`DU_XLEN-1:0]      rdata;

  modport host (output we, output addr, output wdata, input rdata);

  modport bank (input we, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

//--- src/du_regs.sv
`timescale 1ns/1ns
`default_nettype none

`include "du_defines.svh"

module du_regs (
  input  wire                                        clk_i,
  input  wire                                        rst_ni,
  du_reg_if.bank                                     bus,
  input  wire [`DU_BREAKPOINTS-1:0]                  bp_hit_i,
  input  wire                                        step_hit_i,
  input  wire                                        branch_hit_i,
  input  wire [`DU_EXC_W-1:0]                        du_exceptions_i,
  input  wire                                        ex_stall_i,
  input  wire                                        st_flush_i,
  input  wire                                        du_flush_i,
  output du_pkg::bp_reg_t [`DU_BREAKPOINTS-1:0]      bp_o,
  output logic                                       step_ena_o,
  output logic                                       branch_ena_o,
  output logic                                       hit_any_o,
  output logic                                       dbg_bp_o
);

  import du_pkg::*;

  localparam int XLEN = `DU_XLEN;
  localparam int BP   = `DU_BREAKPOINTS;
  localparam int AW   = `DU_DU_ADDR_W;
  localparam int HALF = `DU_EXC_W / 2;

  logic            step_hit_q;
  logic            branch_hit_q;
  logic [BP-1:0]   bp_hit_q;
  logic [XLEN-1:0] cause_q;
  logic [XLEN-1:0] cause_nxt;
  logic            wr_ctrl;
  logic            wr_hit;
  logic            wr_cause;

  assign wr_ctrl  = bus.we && (bus.addr == REG_CTRL);
  assign wr_hit   = bus.we && (bus.addr == REG_HIT);
  assign wr_cause = bus.we && (bus.addr == REG_CAUSE);

  ////////////////////////////////////////////////////////////
  // Control and sticky hit flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      step_ena_o   <= 1'b0;
      branch_ena_o <= 1'b0;
      step_hit_q   <= 1'b0;
      branch_hit_q <= 1'b0;
      bp_hit_q     <= '0;
    end
    else
    begin
      if (wr_ctrl)
      begin
        step_ena_o   <= bus.wdata[0];
        branch_ena_o <= bus.wdata[1];
      end
      // Software write wins over a new hit
      if (wr_hit)
      begin
        step_hit_q   <= bus.wdata[0];
        branch_hit_q <= bus.wdata[1];
        bp_hit_q     <= bus.wdata[4 +: BP];
      end
      else
      begin
        step_hit_q   <= step_hit_q | step_hit_i;
        branch_hit_q <= branch_hit_q | branch_hit_i;
        bp_hit_q     <= bp_hit_q | bp_hit_i;
      end
    end
  end

  assign hit_any_o = step_hit_q | branch_hit_q | (|bp_hit_q);

  ////////////////////////////////////////////////////////////
  // Cause, lowest trap first, then lowest interrupt
  ////////////////////////////////////////////////////////////

  always_comb
  begin
    cause_nxt = '0;
    for (int i = HALF - 1; i >= 0; i--)
    begin
      if (du_exceptions_i[HALF + i])
      begin
        cause_nxt          = '0;
        cause_nxt[XLEN-1]  = 1'b1;
        cause_nxt[4:0]     = i[4:0];
      end
    end
    for (int i = HALF - 1; i >= 0; i--)
    begin
      if (du_exceptions_i[i])
      begin
        cause_nxt      = '0;
        cause_nxt[4:0] = i[4:0];
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      cause_q <= '0;
    else if (wr_cause)
      cause_q <= bus.wdata;
    else if (|du_exceptions_i)
      cause_q <= cause_nxt;
  end

  // Breakpoint control and data words
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      bp_o <= '0;
    else if (bus.we)
    begin
      for (int n = 0; n < BP; n++)
      begin
        if (bus.addr == AW'(REG_BPCTRL0 + 2 * n))
        begin
          bp_o[n].ena <= bus.wdata[1];
          bp_o[n].cc  <= bp_cc_e'(bus.wdata[6:4]);
        end
        if (bus.addr == AW'(REG_BPDATA0 + 2 * n))
          bp_o[n].data <= bus.wdata;
      end
    end
  end

  // Readback
  always_comb
  begin
    bus.rdata = '0;
    case (bus.addr)
      REG_CTRL:  bus.rdata[1:0] = {branch_ena_o, step_ena_o};
      REG_HIT:
      begin
        bus.rdata[1:0]     = {branch_hit_q, step_hit_q};
        bus.rdata[4 +: BP] = bp_hit_q;
      end
      REG_CAUSE: bus.rdata = cause_q;
      default:   bus.rdata = '0;
    endcase
    for (int n = 0; n < BP; n++)
    begin
      if (bus.addr == AW'(REG_BPCTRL0 + 2 * n))
        bus.rdata[6:0] = {bp_o[n].cc, 2'b00, bp_o[n].ena, 1'b1};
      if (bus.addr == AW'(REG_BPDATA0 + 2 * n))
        bus.rdata = bp_o[n].data;
    end
  end

  // Breakpoint to the debug port, held off while the core stalls or flushes
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
      dbg_bp_o <= 1'b0;
    else
      dbg_bp_o <= ~ex_stall_i & ~du_flush_i & ~st_flush_i &
                  ((|du_exceptions_i) | hit_any_o);
  end

  a_cause_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(|du_exceptions_i) && !bus.we |=> $stable(cause_q));

endmodule

`default_nettype wire

//--- src/du_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "du_defines.svh"

module du_top (
  input  wire                      clk_i,
  input  wire                      rst_ni,
  // Debug port
  input  wire                      dbg_stall_i,
  input  wire                      dbg_strb_i,
  input  wire                      dbg_we_i,
  input  wire [`DU_DBG_ADDR_W-1:0] dbg_addr_i,
  input  wire [`DU_XLEN-1:0]       dbg_d_i,
  output logic [`DU_XLEN-1:0]      dbg_q_o,
  output logic                     dbg_ack_o,
  output logic                     dbg_bp_o,
  // Core control
  output logic                     du_stall_o,
  output logic                     du_stall_if_o,
  output logic                     du_latch_nxt_pc_o,
  output logic                     du_flush_o,
  output logic                     du_we_rf_o,
  output logic                     du_we_pc_o,
  output logic [`DU_DU_ADDR_W-1:0] du_addr_o,
  output logic [`DU_XLEN-1:0]      du_d_o,
  input  wire [`DU_XLEN-1:0]       du_rf_q_i,
  input  wire [`DU_XLEN-1:0]       if_nxt_pc_i,
  // Pipeline state
  input  wire                      if_nxt_bubble_i,
  input  wire [31:0]               if_insn_i,
  input  wire                      if_bubble_i,
  input  wire [`DU_XLEN-1:0]       pd_pc_i,
  input  wire                      bu_flush_i,
  input  wire                      st_flush_i,
  input  wire [31:0]               mem_insn_i,
  input  wire                      mem_bubble_i,
  input  wire                      mem_exc_i,
  input  wire [`DU_XLEN-1:0]       mem_memadr_i,
  input  wire                      dmem_ack_i,
  input  wire                      ex_stall_i,
  input  wire [`DU_EXC_W-1:0]      du_exceptions_i
);

  import du_pkg::*;

  bp_reg_t [`DU_BREAKPOINTS-1:0] bp;
  logic [`DU_BREAKPOINTS-1:0]    bp_hit;
  logic                          step_ena;
  logic                          branch_ena;
  logic                          step_hit;
  logic                          branch_hit;
  logic                          hit_any;

  du_reg_if u_bus ();

  du_host_port u_host_port (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dbg_stall_i       (dbg_stall_i),
    .dbg_strb_i        (dbg_strb_i),
    .dbg_we_i          (dbg_we_i),
    .dbg_addr_i        (dbg_addr_i),
    .dbg_d_i           (dbg_d_i),
    .ex_stall_i        (ex_stall_i),
    .hit_any_i         (hit_any),
    .du_rf_q_i         (du_rf_q_i),
    .if_nxt_pc_i       (if_nxt_pc_i),
    .bus               (u_bus.host),
    .dbg_q_o           (dbg_q_o),
    .dbg_ack_o         (dbg_ack_o),
    .du_stall_o        (du_stall_o),
    .du_stall_if_o     (du_stall_if_o),
    .du_latch_nxt_pc_o (du_latch_nxt_pc_o),
    .du_flush_o        (du_flush_o),
    .du_we_rf_o        (du_we_rf_o),
    .du_we_pc_o        (du_we_pc_o),
    .du_addr_o         (du_addr_o),
    .du_d_o            (du_d_o)
  );

  du_regs u_regs (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .bus             (u_bus.bank),
    .bp_hit_i        (bp_hit),
    .step_hit_i      (step_hit),
    .branch_hit_i    (branch_hit),
    .du_exceptions_i (du_exceptions_i),
    .ex_stall_i      (ex_stall_i),
    .st_flush_i      (st_flush_i),
    .du_flush_i      (du_flush_o),
    .bp_o            (bp),
    .step_ena_o      (step_ena),
    .branch_ena_o    (branch_ena),
    .hit_any_o       (hit_any),
    .dbg_bp_o        (dbg_bp_o)
  );

  du_bp_match u_bp_match (
    .bp_i            (bp),
    .step_ena_i      (step_ena),
    .branch_ena_i    (branch_ena),
    .if_nxt_bubble_i (if_nxt_bubble_i),
    .if_insn_i       (if_insn_i),
    .if_bubble_i     (if_bubble_i),
    .pd_pc_i         (pd_pc_i),
    .bu_flush_i      (bu_flush_i),
    .st_flush_i      (st_flush_i),
    .mem_insn_i      (mem_insn_i),
    .mem_bubble_i    (mem_bubble_i),
    .mem_exc_i       (mem_exc_i),
    .mem_memadr_i    (mem_memadr_i),
    .dmem_ack_i      (dmem_ack_i),
    .bp_hit_o        (bp_hit),
    .step_hit_o      (step_hit),
    .branch_hit_o    (branch_hit)
  );

endmodule

`default_nettype wire

//--- verif/du_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "du_defines.svh"

module du_tb;

  localparam logic [2:0] OP_RD    = 3'd0;
  localparam logic [2:0] OP_WR    = 3'd1;
  localparam logic [2:0] OP_WRRF  = 3'd2;
  localparam logic [2:0] OP_NOACK = 3'd3;
  localparam logic [2:0] OP_CORE  = 3'd4;
  localparam logic [2:0] OP_STALL = 3'd5;

  // Core strobes packed into one field of a table row
  localparam logic [4:0] F_ACK   = 5'b00001;
  localparam logic [4:0] F_MEMV  = 5'b00010;
  localparam logic [4:0] F_FLUSH = 5'b00100;
  localparam logic [4:0] F_STEP  = 5'b01000;
  localparam logic [4:0] F_IFV   = 5'b10000;

  localparam logic [31:0] INSN_NOP    = 32'h0000_0013;
  localparam logic [31:0] INSN_LOAD   = 32'h0000_2003;
  localparam logic [31:0] INSN_STORE  = 32'h0000_2023;
  localparam logic [31:0] INSN_BRANCH = 32'h0000_0063;
  localparam logic [31:0] NPC_VAL     = 32'h0000_1F40;
  localparam logic [31:0] RF_VAL      = 32'h5A5A_0005;
  localparam logic [15:0] NPC_ADR     = 16'h1200;

  typedef struct packed {
    logic [2:0]  op;
    logic [15:0] addr;
    logic [31:0] data;
    logic [31:0] insn;
    logic [4:0]  flags;
    logic [31:0] exc;
    logic [31:0] want;
  } row_t;

  logic                      clk_i = 1'b0;
  logic                      rst_ni;
  logic                      dbg_stall_i;
  logic                      dbg_strb_i;
  logic                      dbg_we_i;
  logic [`DU_DBG_ADDR_W-1:0] dbg_addr_i;
  logic [`DU_XLEN-1:0]       dbg_d_i;
  logic [`DU_XLEN-1:0]       dbg_q_o;
  logic                      dbg_ack_o;
  logic                      dbg_bp_o;
  logic                      du_stall_o;
  logic                      du_stall_if_o;
  logic                      du_latch_nxt_pc_o;
  logic                      du_flush_o;
  logic                      du_we_rf_o;
  logic                      du_we_pc_o;
  logic [`DU_DU_ADDR_W-1:0]  du_addr_o;
  logic [`DU_XLEN-1:0]       du_d_o;
  logic [`DU_XLEN-1:0]       du_rf_q_i;
  logic [`DU_XLEN-1:0]       if_nxt_pc_i;
  logic                      if_nxt_bubble_i;
  logic [31:0]               if_insn_i;
  logic                      if_bubble_i;
  logic [`DU_XLEN-1:0]       pd_pc_i;
  logic                      bu_flush_i;
  logic                      st_flush_i;
  logic [31:0]               mem_insn_i;
  logic                      mem_bubble_i;
  logic                      mem_exc_i;
  logic [`DU_XLEN-1:0]       mem_memadr_i;
  logic                      dmem_ack_i;
  logic                      ex_stall_i;
  logic [`DU_EXC_W-1:0]      du_exceptions_i;

  row_t        rows[$];
  logic [31:0] rnd [4];
  logic [31:0] seed;
  int          checks;
  int          errors;

  du_top DUT (.*);

  always #10 clk_i = ~clk_i;

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [15:0] bpctrl_adr(input int n);
    return 16'(16'h0010 + 2 * n);
  endfunction

  function automatic logic [15:0] bpdata_adr(input int n);
    return 16'(16'h0011 + 2 * n);
  endfunction

  task automatic access_entry(input logic [2:0] op, input logic [15:0] addr,
                              input logic [31:0] data, input logic [31:0] want);
    row_t r;
    r      = '0;
    r.op   = op;
    r.addr = addr;
    r.data = data;
    r.want = want;
    rows.push_back(r);
  endtask

  task automatic core_entry(input logic [31:0] adr, input logic [31:0] insn,
                            input logic [4:0] flags, input logic [31:0] exc,
                            input logic [1:0] bp_want);
    row_t r;
    r       = '0;
    r.op    = OP_CORE;
    r.data  = adr;
    r.insn  = insn;
    r.flags = flags;
    r.exc   = exc;
    r.want  = {30'b0, bp_want};
    rows.push_back(r);
  endtask

  task automatic expect_eq(input string what, input logic [31:0] got,
                           input logic [31:0] want);
    checks++;
    assert (got === want)
    else
    begin
      errors++;
      $display("Fail %0t: %s is %h, expected %h", $time, what, got, want);
    end
  endtask

  task automatic drive_core(input logic [31:0] adr, input logic [31:0] insn,
                            input logic [4:0] flags, input logic [31:0] exc);
    pd_pc_i         = adr;
    mem_memadr_i    = adr;
    if_insn_i       = insn;
    mem_insn_i      = insn;
    dmem_ack_i      = flags[0];
    mem_bubble_i    = ~flags[1];
    bu_flush_i      = flags[2];
    if_nxt_bubble_i = ~flags[3];
    if_bubble_i     = ~flags[4];
    du_exceptions_i = exc;
  endtask

  ////////////////////////////////////////////////////////////
  // Row execution
  ////////////////////////////////////////////////////////////

  task automatic bus_access(input row_t r);
    int          edges;
    int          rf_pulses;
    int          pc_pulses;
    logic [11:0] rf_addr;
    logic [31:0] rf_data;
    logic [31:0] pc_data;
    logic        pc_write;
    edges      = 0;
    rf_pulses  = 0;
    pc_pulses  = 0;
    rf_addr    = '0;
    rf_data    = '0;
    pc_data    = '0;
    pc_write   = (r.op == OP_WR) && (r.addr == NPC_ADR);
    dbg_addr_i = r.addr;
    dbg_d_i    = r.data;
    dbg_we_i   = (r.op != OP_RD);
    dbg_strb_i = 1'b1;
    while (!dbg_ack_o && edges < 20)
    begin
      @(negedge clk_i);
      edges++;
      if (du_we_rf_o)
      begin
        rf_pulses++;
        rf_addr = du_addr_o;
        rf_data = du_d_o;
      end
      if (du_we_pc_o)
      begin
        pc_pulses++;
        pc_data = du_d_o;
      end
    end
    checks++;
    assert (edges == 3)
    else
    begin
      errors++;
      if (!dbg_ack_o)
        $display("No acknowledge for address %h within 20 cycles", r.addr);
      else
        $display("Fail %0t: acknowledge after %0d edges, expected 3", $time, edges);
    end
    if (r.op == OP_RD)
      expect_eq("read data", dbg_q_o, r.want);
    dbg_strb_i = 1'b0;
    dbg_we_i   = 1'b0;
    expect_eq("rf write pulses", rf_pulses, 32'(r.op == OP_WRRF));
    if (r.op == OP_WRRF)
    begin
      expect_eq("rf write address", 32'(rf_addr), 32'(r.addr[11:0]));
      expect_eq("rf write data", rf_data, r.data);
    end
    expect_eq("pc write pulses", pc_pulses, 32'(pc_write));
    if (pc_write)
      expect_eq("pc write data", pc_data, r.data);
    @(negedge clk_i);
    expect_eq("ack one cycle later", 32'(dbg_ack_o), 32'h0);
  endtask

  // GPR bank with the core running must stay silent
  task automatic blocked_access(input row_t r);
    int acks;
    acks       = 0;
    dbg_addr_i = r.addr;
    dbg_we_i   = 1'b0;
    dbg_strb_i = 1'b1;
    repeat (10)
    begin
      @(negedge clk_i);
      if (dbg_ack_o)
        acks++;
    end
    checks++;
    assert (acks == 0)
    else
    begin
      errors++;
      $display("Access to %h was acknowledged while the core was running", r.addr);
    end
    dbg_strb_i = 1'b0;
    @(negedge clk_i);
  endtask

  task automatic pulse_core(input row_t r);
    drive_core(r.data, r.insn, r.flags, r.exc);
    @(negedge clk_i);
    expect_eq("dbg_bp_o first cycle", 32'(dbg_bp_o), 32'(r.want[0]));
    // A sticky hit flag stalls instruction fetch
    expect_eq("du_stall_if_o", 32'(du_stall_if_o), 32'(r.want[1]));
    drive_core(32'h0, INSN_NOP, 5'b0, 32'h0);
    @(negedge clk_i);
    expect_eq("dbg_bp_o second cycle", 32'(dbg_bp_o), 32'(r.want[1]));
  endtask

  task automatic set_stall(input row_t r);
    int latch_cnt;
    int flush_cnt;
    latch_cnt   = 0;
    flush_cnt   = 0;
    dbg_stall_i = r.data[0];
    // Pulses live between the falling and the next rising edge
    repeat (4)
    begin
      #5;
      if (du_latch_nxt_pc_o)
        latch_cnt++;
      if (du_flush_o)
        flush_cnt++;
      @(negedge clk_i);
    end
    expect_eq("du_stall_o", 32'(du_stall_o), 32'(r.data[0]));
    expect_eq("du_stall_if_o", 32'(du_stall_if_o), 32'(r.data[0]));
    expect_eq("latch pulses", latch_cnt, 32'(r.data[0]));
    expect_eq("flush pulses", flush_cnt, 32'(!r.data[0]));
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus table
  ////////////////////////////////////////////////////////////

  task automatic fill_table();
    // Reset values
    access_entry(OP_RD, 16'h0000, 32'h0, 32'h0);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h0);
    access_entry(OP_RD, 16'h0002, 32'h0, 32'h0);
    for (int n = 0; n < 4; n++)
      access_entry(OP_RD, bpctrl_adr(n), 32'h0, 32'h1);
    access_entry(OP_NOACK, 16'h1005, 32'h0, 32'h0);
    // Field layout of the breakpoint registers
    access_entry(OP_WR, bpctrl_adr(2), 32'h72, 32'h0);
    access_entry(OP_RD, bpctrl_adr(2), 32'h0, 32'h73);
    access_entry(OP_WR, bpctrl_adr(3), 32'hFFFF_FFFF, 32'h0);
    access_entry(OP_RD, bpctrl_adr(3), 32'h0, 32'h73);
    access_entry(OP_WR, bpdata_adr(2), rnd[2], 32'h0);
    access_entry(OP_RD, bpdata_adr(2), 32'h0, rnd[2]);
    // Fetch breakpoint
    access_entry(OP_WR, bpdata_adr(0), rnd[0], 32'h0);
    access_entry(OP_WR, bpctrl_adr(0), 32'h02, 32'h0);
    access_entry(OP_RD, bpctrl_adr(0), 32'h0, 32'h03);
    core_entry(rnd[0], INSN_NOP, 5'b0, 32'h0, 2'b10);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h10);
    access_entry(OP_WR, 16'h0001, 32'h0, 32'h0);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h0);
    core_entry(rnd[0], INSN_NOP, F_FLUSH, 32'h0, 2'b00);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h0);
    access_entry(OP_WR, bpctrl_adr(0), 32'h0, 32'h0);
    // Load address breakpoint followed by load or store address
    access_entry(OP_WR, bpdata_adr(1), rnd[1], 32'h0);
    access_entry(OP_WR, bpctrl_adr(1), 32'h12, 32'h0);
    access_entry(OP_RD, bpctrl_adr(1), 32'h0, 32'h13);
    core_entry(rnd[1], INSN_LOAD, F_ACK | F_MEMV, 32'h0, 2'b10);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h20);
    access_entry(OP_WR, 16'h0001, 32'h0, 32'h0);
    core_entry(rnd[1], INSN_STORE, F_ACK | F_MEMV, 32'h0, 2'b00);
    core_entry(rnd[1], INSN_LOAD, F_MEMV, 32'h0, 2'b00);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h0);
    access_entry(OP_WR, bpctrl_adr(1), 32'h32, 32'h0);
    access_entry(OP_RD, bpctrl_adr(1), 32'h0, 32'h33);
    core_entry(rnd[1], INSN_STORE, F_ACK | F_MEMV, 32'h0, 2'b10);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h20);
    access_entry(OP_WR, 16'h0001, 32'h0, 32'h0);
    core_entry(rnd[1], INSN_LOAD, F_ACK | F_MEMV, 32'h0, 2'b10);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h20);
    access_entry(OP_WR, 16'h0001, 32'h0, 32'h0);
    access_entry(OP_WR, bpctrl_adr(1), 32'h0, 32'h0);
    // Single step, branch break and cause
    access_entry(OP_WR, 16'h0000, 32'h1, 32'h0);
    access_entry(OP_RD, 16'h0000, 32'h0, 32'h1);
    core_entry(32'h0, INSN_NOP, F_STEP, 32'h0, 2'b10);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h1);
    access_entry(OP_WR, 16'h0001, 32'h0, 32'h0);
    access_entry(OP_WR, 16'h0000, 32'h2, 32'h0);
    access_entry(OP_RD, 16'h0000, 32'h0, 32'h2);
    core_entry(32'h0, INSN_BRANCH, F_IFV, 32'h0, 2'b10);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h2);
    access_entry(OP_WR, 16'h0001, 32'h0, 32'h0);
    core_entry(32'h0, INSN_LOAD, F_IFV, 32'h0, 2'b00);
    access_entry(OP_RD, 16'h0001, 32'h0, 32'h0);
    access_entry(OP_WR, 16'h0000, 32'h0, 32'h0);
    core_entry(32'h0, INSN_NOP, 5'b0, 32'h28, 2'b01);
    access_entry(OP_RD, 16'h0002, 32'h0, 32'h3);
    core_entry(32'h0, INSN_NOP, 5'b0, 32'h0004_0000, 2'b01);
    access_entry(OP_RD, 16'h0002, 32'h0, 32'h8000_0002);
    // Core halted by the debugger
    access_entry(OP_STALL, 16'h0000, 32'h1, 32'h0);
    access_entry(OP_WRRF, 16'h1005, rnd[3], 32'h0);
    access_entry(OP_WR, NPC_ADR, rnd[3], 32'h0);
    access_entry(OP_RD, NPC_ADR, 32'h0, NPC_VAL);
    access_entry(OP_RD, 16'h1005, 32'h0, RF_VAL);
    access_entry(OP_STALL, 16'h0000, 32'h0, 32'h0);
  endtask

  initial
  begin
    #1;
    #(rows.size() * 20 * 20 + 8 * 20);
    $display("Watchdog expired before all table rows were applied");
    $display("Test FAILED");
    $finish;
  end

  initial
  begin
    checks      = 0;
    errors      = 0;
    rst_ni      = 1'b0;
    dbg_stall_i = 1'b0;
    dbg_strb_i  = 1'b0;
    dbg_we_i    = 1'b0;
    dbg_addr_i  = '0;
    dbg_d_i     = '0;
    du_rf_q_i   = RF_VAL;
    if_nxt_pc_i = NPC_VAL;
    st_flush_i  = 1'b0;
    mem_exc_i   = 1'b0;
    ex_stall_i  = 1'b0;
    drive_core(32'h0, INSN_NOP, 5'b0, 32'h0);
    seed = 32'd40;
    for (int i = 0; i < 4; i++)
    begin
      seed   = xorshift(seed);
      rnd[i] = seed;
    end
    fill_table();
    repeat (8) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);
    foreach (rows[i])
    begin
      case (rows[i].op)
        OP_CORE:  pulse_core(rows[i]);
        OP_STALL: set_stall(rows[i]);
        OP_NOACK: blocked_access(rows[i]);
        default:  bus_access(rows[i]);
      endcase
    end
    $display("Done: %0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Test OK");
    else
      $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+src
src/du_pkg.sv
src/du_reg_if.sv
src/du_bp_match.sv
src/du_regs.sv
src/du_host_port.sv
src/du_top.sv
verif/du_tb.sv
